//--- source/patt_pkg.sv
// Shared widths, register map and register word layout for the pattern
// generator and checker. Imported by every module of the loopback subsystem.

`default_nettype none

package patt_pkg;

   // ------------------------------------------------------------
   // Widths
   // ------------------------------------------------------------
   // Pattern words and register words
   localparam int DATA_W = 32;
   // Strobe period field, period is rate+1 cycles
   localparam int RATE_W = 5;
   // Counter step field, step is inc_step+1
   localparam int STEP_W = 3;
   // Interrupted run counter
   localparam int ERR_W  = 16;

   // ------------------------------------------------------------
   // Register map and encodings
   // ------------------------------------------------------------
   localparam logic ADDR_CTRL = 1'b0;
   localparam logic ADDR_USR  = 1'b1;

   // Test mode values
   localparam logic TMODE_CNT = 1'b0;
   localparam logic TMODE_USR = 1'b1;

   // Control register layout, listed from the top bit down
   typedef struct packed {
      logic [21:0]       reserved;
      logic [STEP_W-1:0] inc_step;
      logic              test_mode;
      logic [RATE_W-1:0] rate;
      logic              pgen_disable;
   } ctrl_fields_t;

   // One bus word, seen as control fields or as the raw user word
   typedef union packed {
      ctrl_fields_t      ctrl_fields;
      logic [DATA_W-1:0] raw;
   } reg_word_u;

endpackage

`default_nettype wire

//--- source/patt_regs.sv
// Register block for the loopback pattern engines. Bus writes land on the
// next clock and are held as levels for the generator, strobe and checker.

`timescale 1ns/100ps
`default_nettype none

module patt_regs (
   input  logic                           clk,
   input  logic                           rst,
   // Write-only register bus, no acknowledge
   input  logic                           reg_wr,
   input  logic                           reg_addr,
   input  patt_pkg::reg_word_u            reg_wdata,
   // Settings for the pattern engines
   output logic                           pgen_disable,
   output logic [patt_pkg::RATE_W-1:0]    rate,
   output logic                           test_mode,
   output logic [patt_pkg::STEP_W-1:0]    inc_step,
   output logic [patt_pkg::DATA_W-1:0]    usr_data
);
   import patt_pkg::*;

   // ------------------------------------------------------------
   // Decode of the write word
   // ------------------------------------------------------------
   // Write strobes per address
   logic wr_ctrl;
   logic wr_usr;

   assign wr_ctrl = reg_wr && (reg_addr == ADDR_CTRL);
   assign wr_usr  = reg_wr && (reg_addr == ADDR_USR);

   // ------------------------------------------------------------
   // Control register
   // ------------------------------------------------------------
   // Comes out of reset with the engines stopped
   always_ff @(posedge clk) begin
      if (rst) begin
         pgen_disable <= 1'b1;
         rate         <= '0;
         test_mode    <= TMODE_CNT;
         inc_step     <= '0;
      end else if (wr_ctrl) begin
         // Field view of the bus word
         pgen_disable <= reg_wdata.ctrl_fields.pgen_disable;
         rate         <= reg_wdata.ctrl_fields.rate;
         test_mode    <= reg_wdata.ctrl_fields.test_mode;
         inc_step     <= reg_wdata.ctrl_fields.inc_step;
      end
   end

   // ------------------------------------------------------------
   // User data register
   // ------------------------------------------------------------
   // Fixed word sent and expected in user mode
   always_ff @(posedge clk) begin
      if (rst) begin
         usr_data <= '0;
      end else if (wr_usr) begin
         // Raw view, all 32 bits taken as they are
         usr_data <= reg_wdata.raw;
      end
   end

endmodule

`default_nettype wire

//--- source/rate_strobe.sv
// Programmable divider for the pattern generator. While enabled it gives a
// one-cycle strobe every rate+1 clocks, starting one cycle after enable.

`timescale 1ns/100ps
`default_nettype none

module rate_strobe (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        enable,
   input  logic [patt_pkg::RATE_W-1:0] rate,
   output logic                        stb
);
   import patt_pkg::*;

   // Cycles left until the next pulse
   logic [RATE_W-1:0] cnt;

   // ------------------------------------------------------------
   // Down-counter with reload
   // ------------------------------------------------------------
   // Held at zero while stopped so the first pulse is immediate
   always_ff @(posedge clk) begin
      if (rst || !enable) begin
         cnt <= '0;
         stb <= 1'b0;
      end else if (cnt == '0) begin
         // Pulse and reload, new rate values are picked up here
         stb <= 1'b1;
         cnt <= rate;
      end else begin
         stb <= 1'b0;
         cnt <= cnt - 1'b1;
      end
   end

   // ------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------
   // A steady nonzero rate leaves at least one idle cycle between pulses
   a_stb_spacing : assert property (
      @(posedge clk) disable iff (rst)
      (stb && (rate != '0) && $stable(rate)) |=> !stb
   ) else $error("rate_strobe: back to back strobes with rate %0d", rate);

endmodule

`default_nettype wire

//--- source/patt_gen.sv
// Pattern generator for the link loopback test. On each strobe it sends
// either the wrapping counter value or the fixed user word.

`timescale 1ns/100ps
`default_nettype none

module patt_gen #(
   parameter int CNT_W = 7
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        pgen_disable,
   input  logic                        gen_stb,
   input  logic                        test_mode,
   input  logic [patt_pkg::STEP_W-1:0] inc_step,
   input  logic [patt_pkg::DATA_W-1:0] usr_data,
   output logic                        tx_valid,
   output logic [patt_pkg::DATA_W-1:0] tx_data
);
   import patt_pkg::*;

   // ------------------------------------------------------------
   // Step counter
   // ------------------------------------------------------------
   logic [CNT_W-1:0] cnt;
   // Actual step from 1 to 8
   logic [STEP_W:0]  step;
   // One extra bit to see the wrap
   logic [CNT_W:0]   cnt_sum;

   assign step    = {1'b0, inc_step} + 1'b1;
   assign cnt_sum = {1'b0, cnt} + {{(CNT_W - STEP_W){1'b0}}, step};

   // Back to zero whenever the sum leaves the counter range
   always_ff @(posedge clk) begin
      if (rst || pgen_disable) begin
         cnt <= '0;
      end else if (gen_stb) begin
         cnt <= cnt_sum[CNT_W] ? '0 : cnt_sum[CNT_W-1:0];
      end
   end

   // ------------------------------------------------------------
   // Output word
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst || pgen_disable) begin
         tx_valid <= 1'b0;
      end else begin
         tx_valid <= gen_stb;
      end
   end

   // Qualified by tx_valid
   always_ff @(posedge clk) begin
      if (gen_stb) begin
         tx_data <= (test_mode == TMODE_CNT) ? {{(DATA_W - CNT_W){1'b0}}, cnt} : usr_data;
      end
   end

   // ------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------
   // A settled disable keeps the strobe away and no word leaves
   a_no_tx_disabled : assert property (
      @(posedge clk) disable iff (rst)
      (pgen_disable && $past(pgen_disable)) |-> (!gen_stb && !tx_valid)
   ) else $error("patt_gen: strobe or tx_valid while disabled");

endmodule

`default_nettype wire

//--- source/patt_chk.sv
// Pattern checker for the link loopback test. Locks onto the received
// sequence with a two-value window, flags the match state and counts
// how often a matching run is broken.

`timescale 1ns/100ps
`default_nettype none

module patt_chk #(
   parameter int CNT_W = 7
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        pgen_disable,
   input  logic                        test_mode,
   input  logic [patt_pkg::STEP_W-1:0] inc_step,
   input  logic [patt_pkg::DATA_W-1:0] usr_data,
   input  logic                        rx_valid,
   input  logic [patt_pkg::DATA_W-1:0] rx_data,
   output logic                        rx_match,
   output logic [patt_pkg::ERR_W-1:0]  rx_err_cnt
);
   import patt_pkg::*;

   // ------------------------------------------------------------
   // Expected value counter
   // ------------------------------------------------------------
   // Same step and wrap rule as the generator
   logic [CNT_W-1:0]  cnt;
   logic [STEP_W:0]   step;
   logic [CNT_W:0]    cnt_sum;
   logic [CNT_W-1:0]  cnt_next;

   assign step     = {1'b0, inc_step} + 1'b1;
   assign cnt_sum  = {1'b0, cnt} + {{(CNT_W - STEP_W){1'b0}}, step};
   assign cnt_next = cnt_sum[CNT_W] ? '0 : cnt_sum[CNT_W-1:0];

   // ------------------------------------------------------------
   // Window compare
   // ------------------------------------------------------------
   // Last accepted word
   logic [DATA_W-1:0] held;
   logic [DATA_W-1:0] ref_cur;
   logic [DATA_W-1:0] ref_next;
   logic              match_cur;
   logic              match_next;
   logic              in_seq;

   // In user mode the fixed word is the only value that repeats
   assign ref_cur    = (test_mode == TMODE_USR) ? usr_data : held;
   assign ref_next   = {{(DATA_W - CNT_W){1'b0}}, cnt};
   assign match_cur  = (rx_data == ref_cur);
   assign match_next = (rx_data == ref_next);
   // Repeats of the current value are fine, idle links resend
   assign in_seq     = match_cur || match_next;

   // ------------------------------------------------------------
   // Lock state and status
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst || pgen_disable) begin
         cnt        <= '0;
         held       <= '0;
         rx_match   <= 1'b0;
         rx_err_cnt <= '0;
      end else if (rx_valid) begin
         rx_match <= in_seq;
         if (match_next) begin
            // Step forward on the expected next word
            cnt  <= cnt_next;
            held <= rx_data;
         end else if (!in_seq) begin
            // Lost, wait for the sequence to come round to zero
            cnt <= '0;
         end
         // Count broken runs, stop at the top value
         if (rx_match && !in_seq && (rx_err_cnt != {ERR_W{1'b1}})) begin
            rx_err_cnt <= rx_err_cnt + 1'b1;
         end
      end
   end

   // ------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------
   // Error count only moves up while enabled, no wrap at saturation
   a_err_monotonic : assert property (
      @(posedge clk) disable iff (rst)
      !pgen_disable |=> (rx_err_cnt >= $past(rx_err_cnt))
   ) else $error("patt_chk: rx_err_cnt went down from %0d", $past(rx_err_cnt));

endmodule

`default_nettype wire

//--- source/patt_top.sv
// Top level of the loopback test subsystem. Generator and checker sit side
// by side under one register block; the link is closed outside this module.

`timescale 1ns/100ps
`default_nettype none

module patt_top #(
   parameter int CNT_W = 7
) (
   input  logic                        clk,
   input  logic                        rst,
   // Register bus
   input  logic                        reg_wr,
   input  logic                        reg_addr,
   input  patt_pkg::reg_word_u         reg_wdata,
   // Link transmit side
   output logic                        tx_valid,
   output logic [patt_pkg::DATA_W-1:0] tx_data,
   // Link receive side
   input  logic                        rx_valid,
   input  logic [patt_pkg::DATA_W-1:0] rx_data,
   // Checker status
   output logic                        rx_match,
   output logic [patt_pkg::ERR_W-1:0]  rx_err_cnt
);
   import patt_pkg::*;

   // ------------------------------------------------------------
   // Settings shared by both engines
   // ------------------------------------------------------------
   logic              pgen_disable;
   logic [RATE_W-1:0] rate;
   logic              test_mode;
   logic [STEP_W-1:0] inc_step;
   logic [DATA_W-1:0] usr_data;
   // Word pacing for the generator
   logic              gen_stb;

   patt_regs u_regs (
      .clk          (clk),
      .rst          (rst),
      .reg_wr       (reg_wr),
      .reg_addr     (reg_addr),
      .reg_wdata    (reg_wdata),
      .pgen_disable (pgen_disable),
      .rate         (rate),
      .test_mode    (test_mode),
      .inc_step     (inc_step),
      .usr_data     (usr_data)
   );

   // Strobe runs whenever the engines are enabled
   rate_strobe u_stb (
      .clk    (clk),
      .rst    (rst),
      .enable (~pgen_disable),
      .rate   (rate),
      .stb    (gen_stb)
   );

   patt_gen #(
      .CNT_W (CNT_W)
   ) u_gen (
      .clk          (clk),
      .rst          (rst),
      .pgen_disable (pgen_disable),
      .gen_stb      (gen_stb),
      .test_mode    (test_mode),
      .inc_step     (inc_step),
      .usr_data     (usr_data),
      .tx_valid     (tx_valid),
      .tx_data      (tx_data)
   );

   patt_chk #(
      .CNT_W (CNT_W)
   ) u_chk (
      .clk          (clk),
      .rst          (rst),
      .pgen_disable (pgen_disable),
      .test_mode    (test_mode),
      .inc_step     (inc_step),
      .usr_data     (usr_data),
      .rx_valid     (rx_valid),
      .rx_data      (rx_data),
      .rx_match     (rx_match),
      .rx_err_cnt   (rx_err_cnt)
   );

endmodule

`default_nettype wire

//--- test/patt_tb.sv
// Loopback testbench for the pattern subsystem. Closes tx to rx outside the
// DUT, flips single bits in chosen words and checks every word and status
// port against a reference model of the generator and checker rules.

`timescale 1ns/100ps
`default_nettype none

module patt_tb;

   // ------------------------------------------------------------
   // Test lengths and timeout budget
   // ------------------------------------------------------------
   // Small counter so wraps come quickly
   localparam int CNT_W       = 5;
   localparam int WRAP        = 1 << CNT_W;
   localparam int LOOP_WORDS  = 80;
   localparam int RATE_WORDS  = 6;
   localparam int STEP_WORDS  = 40;
   localparam int USR_WORDS   = 30;
   localparam int USR_RATE    = 2;
   localparam int LOCK_WORDS  = 40;
   localparam int N_INJECT    = 4;
   localparam int DIS_WORDS   = 20;
   // Stop, idle and restart of one run
   localparam int RUN_SETUP   = 16;
   localparam logic [31:0] USR_WORD = 32'ha5c3_0f96;
   // Rates 1, 3, 7 and 20 give periods 2, 4, 8 and 21
   localparam int TEST_CYCLES = LOOP_WORDS + RATE_WORDS * (2 + 4 + 8 + 21)
                              + 2 * STEP_WORDS + (USR_WORDS + 1) * (USR_RATE + 1)
                              + LOCK_WORDS + N_INJECT * (3 * WRAP + 16)
                              + DIS_WORDS + 12 * RUN_SETUP;
   localparam int TIMEOUT     = TEST_CYCLES + 200;

   // DUT ports
   logic        clk;
   logic        rst;
   logic        reg_wr;
   logic        reg_addr;
   logic [31:0] reg_wdata;
   logic        tx_valid;
   logic [31:0] tx_data;
   logic        rx_valid = 1'b0;
   logic [31:0] rx_data  = '0;
   logic        rx_match;
   logic [15:0] rx_err_cnt;

   // Bookkeeping
   int          errors   = 0;
   int          tx_count = 0;
   int          cyc      = 0;
   int          last_cyc = 0;
   bit          have_last = 1'b0;
   bit          dis_prev  = 1'b0;
   integer      seed      = 32'h02a5_5b82;

   // Model copy of the settings the DUT holds
   logic        m_dis  = 1'b1;
   logic [4:0]  m_rate = '0;
   logic        m_mode = 1'b0;
   logic [2:0]  m_step = '0;
   logic [31:0] m_usr  = '0;
   // Last fields written and kept across a stop
   int          cur_rate = 0;
   logic        cur_mode = 1'b0;
   int          cur_step = 0;

   // Generator and checker model state
   logic [31:0] g_cnt   = '0;
   logic [31:0] c_cnt   = '0;
   logic [31:0] c_held  = '0;
   logic        c_match = 1'b0;
   logic [15:0] c_err   = '0;

   // Corruption requests from the stimulus and grants from the loopback
   int          inject_req    = 0;
   int          n_injected    = 0;
   logic [31:0] inject_target = '0;
   int          inject_bit    = 0;

   patt_top #(
      .CNT_W (CNT_W)
   ) uut (
      .clk        (clk),
      .rst        (rst),
      .reg_wr     (reg_wr),
      .reg_addr   (reg_addr),
      .reg_wdata  (reg_wdata),
      .tx_valid   (tx_valid),
      .tx_data    (tx_data),
      .rx_valid   (rx_valid),
      .rx_data    (rx_data),
      .rx_match   (rx_match),
      .rx_err_cnt (rx_err_cnt)
   );

   // ------------------------------------------------------------
   // Reference rules and helpers
   // ------------------------------------------------------------
   // Step is inc_step+1 and the sum drops to zero once it reaches the range
   function automatic logic [31:0] next_value(input logic [31:0] v, input logic [2:0] inc_step);
      int sum;
      sum = int'(v) + int'(inc_step) + 1;
      if (sum >= WRAP)
         return '0;
      return sum;
   endfunction

   // Control word with disable in bit 0 and the fields above it
   function automatic logic [31:0] ctrl_word(input logic dis, input int rate, input logic mode,
                                             input int step);
      logic [31:0] w;
      w      = '0;
      w[0]   = dis;
      w[5:1] = rate[4:0];
      w[6]   = mode;
      w[9:7] = step[2:0];
      return w;
   endfunction

   task automatic compare_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      end
   endtask

   // One bus write held for a single clock
   task automatic write_reg(input logic addr, input logic [31:0] data);
      @(posedge clk);
      reg_wr    <= 1'b1;
      reg_addr  <= addr;
      reg_wdata <= data;
      @(posedge clk);
      reg_wr    <= 1'b0;
   endtask

   // Stop with the old fields and restart with new ones
   task automatic start_run(input int rate, input logic mode, input int step);
      write_reg(1'b0, ctrl_word(1'b1, cur_rate, cur_mode, cur_step));
      repeat (4) @(posedge clk);
      write_reg(1'b0, ctrl_word(1'b0, rate, mode, step));
      cur_rate = rate;
      cur_mode = mode;
      cur_step = step;
   endtask

   // Counted by the model process on the falling edge
   task automatic wait_words(input int n);
      int target;
      target = tx_count + n;
      while (tx_count < target)
         @(posedge clk);
   endtask

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ------------------------------------------------------------
   // Loopback with optional single bit corruption
   // ------------------------------------------------------------
   always @(posedge clk) begin
      if (rst) begin
         rx_valid <= 1'b0;
         rx_data  <= '0;
      end else begin
         rx_valid <= tx_valid;
         if (tx_valid && (inject_req != n_injected) && (tx_data == inject_target)) begin
            rx_data    <= tx_data ^ (32'h1 << inject_bit);
            n_injected <= n_injected + 1;
         end else begin
            rx_data <= tx_data;
         end
      end
   end

   // ------------------------------------------------------------
   // Model and compare on the falling edge where outputs are stable
   // ------------------------------------------------------------
   always @(negedge clk) begin : model
      logic [31:0] ref_cur;
      logic        hit_next;
      logic        in_seq;
      cyc++;
      compare_value("rx_match", rx_match, c_match);
      compare_value("rx_err_cnt", rx_err_cnt, c_err);
      if (dis_prev)
         compare_value("tx_valid while disabled", tx_valid, 0);
      if (tx_valid === 1'b1) begin
         tx_count++;
         if (m_mode) begin
            compare_value("user word", tx_data, m_usr);
         end else begin
            compare_value("counter word", tx_data, g_cnt);
            g_cnt = next_value(g_cnt, m_step);
         end
         if (have_last)
            compare_value("strobe spacing", cyc - last_cyc, m_rate + 1);
         have_last = 1'b1;
         last_cyc  = cyc;
      end
      // Generator restarts at zero after a stop
      dis_prev = m_dis;
      if (rst || m_dis) begin
         g_cnt     = '0;
         have_last = 1'b0;
      end
      // Checker window for the rx word taken at the next rising edge
      if (rst || m_dis) begin
         c_cnt   = '0;
         c_held  = '0;
         c_match = 1'b0;
         c_err   = '0;
      end else if (rx_valid) begin
         ref_cur  = m_mode ? m_usr : c_held;
         hit_next = (rx_data == c_cnt);
         in_seq   = hit_next || (rx_data == ref_cur);
         if (c_match && !in_seq && (c_err != 16'hffff))
            c_err++;
         if (hit_next) begin
            c_cnt  = next_value(c_cnt, m_step);
            c_held = rx_data;
         end else if (!in_seq) begin
            c_cnt = '0;
         end
         c_match = in_seq;
      end
      // A pending write lands at the next rising edge
      if (rst) begin
         m_dis  = 1'b1;
         m_rate = '0;
         m_mode = 1'b0;
         m_step = '0;
      end else if (reg_wr && !reg_addr) begin
         m_dis  = reg_wdata[0];
         m_rate = reg_wdata[5:1];
         m_mode = reg_wdata[6];
         m_step = reg_wdata[9:7];
      end else if (reg_wr) begin
         m_usr = reg_wdata;
      end
   end

   // ------------------------------------------------------------
   // Stimulus
   // ------------------------------------------------------------
   initial begin : stimulus
      logic [31:0] relock_rx;
      rst       = 1'b1;
      reg_wr    = 1'b0;
      reg_addr  = 1'b0;
      reg_wdata = '0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;

      // Full rate count over several wraps
      start_run(0, 1'b0, 0);
      wait_words(LOOP_WORDS);
      @(negedge clk);
      compare_value("lock in counter mode", rx_match, 1);

      // Spacing of tx_valid per rate
      start_run(1, 1'b0, 0);
      wait_words(RATE_WORDS);
      start_run(3, 1'b0, 0);
      wait_words(RATE_WORDS);
      start_run(7, 1'b0, 0);
      wait_words(RATE_WORDS);
      start_run(20, 1'b0, 0);
      wait_words(RATE_WORDS);

      // Steps 3 and 8
      start_run(0, 1'b0, 2);
      wait_words(STEP_WORDS);
      start_run(0, 1'b0, 7);
      wait_words(STEP_WORDS);

      // Fixed user word where repeats stay matched
      write_reg(1'b1, USR_WORD);
      start_run(USR_RATE, 1'b1, 0);
      wait_words(USR_WORDS + 1);
      @(negedge clk);
      compare_value("lock in user mode", rx_match, 1);
      // The stop before this run cleared the count
      compare_value("errors in user mode", rx_err_cnt, 0);

      // Single bit flips above the counter range spaced beyond a full wrap
      start_run(0, 1'b0, 0);
      wait_words(LOCK_WORDS);
      for (int i = 0; i < N_INJECT; i++) begin
         @(posedge clk);
         inject_target <= 1 + ({$random(seed)} % (WRAP - 1));
         inject_bit    <= CNT_W + ({$random(seed)} % (32 - CNT_W));
         inject_req    <= inject_req + 1;
         @(negedge clk);
         while (n_injected != inject_req)
            @(negedge clk);
         @(negedge clk);
         compare_value("match after corruption", rx_match, 0);
         compare_value("error step", rx_err_cnt, i + 1);
         // Word on the link just before the match comes back
         relock_rx = '1;
         while (rx_match !== 1'b1) begin
            relock_rx = rx_data;
            @(negedge clk);
         end
         compare_value("relock word", relock_rx, 0);
         compare_value("errors after relock", rx_err_cnt, i + 1);
         wait_words(WRAP + 8);
      end

      // Stop clears status and restart begins at zero
      @(negedge clk);
      compare_value("errors before stop", rx_err_cnt, N_INJECT);
      write_reg(1'b0, ctrl_word(1'b1, cur_rate, cur_mode, cur_step));
      repeat (3) @(negedge clk);
      compare_value("tx_valid after stop", tx_valid, 0);
      compare_value("match after stop", rx_match, 0);
      compare_value("errors after stop", rx_err_cnt, 0);
      write_reg(1'b0, ctrl_word(1'b0, cur_rate, cur_mode, cur_step));
      @(negedge clk);
      while (tx_valid !== 1'b1)
         @(negedge clk);
      compare_value("first word after restart", tx_data, 0);
      wait_words(DIS_WORDS);
      @(negedge clk);
      compare_value("lock after restart", rx_match, 1);

      $display("Run complete: %0d errors over %0d words", errors, tx_count);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

   // Ends a run that stops making progress
   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles < TIMEOUT) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: the test was still running after %0d cycles", TIMEOUT);
      $display("Run aborted: %0d errors over %0d words", errors, tx_count);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- vlog.f
source/patt_pkg.sv
source/patt_regs.sv
source/rate_strobe.sv
source/patt_gen.sv
source/patt_chk.sv
source/patt_top.sv
test/patt_tb.sv

//--- Bender.yml
package:
  name: patt_loopback

sources:
  # Package first, then the RTL from the leaves up
  - files:
      - source/patt_pkg.sv
      - source/patt_regs.sv
      - source/rate_strobe.sv
      - source/patt_gen.sv
      - source/patt_chk.sv
      - source/patt_top.sv

  # Loopback testbench
  - target: test
    files:
      - test/patt_tb.sv
